// File: hw/ctl_pkg.sv
`default_nettype none
// ##############################
// 6502 sequencer definitions
// Bus widths, FSM states, opcodes,
// address modes and field codes
// ##############################
package ctl_pkg;

    localparam int DB_W      = 8;        // Data bus
    localparam int AB_OP_W   = 12;       // PC/AHL/ABH + ABL sel + operand + carry
    localparam int REG_OP_W  = 7;        // {write, dst[1:0], src[3:0]}
    localparam int ALU_OP_W  = 9;        // {ldm, bcd, shift[1:0], add[2:0], carry[1:0]}
    localparam int ALU_SEL_W = 7;        // {shift, add, carry} part kept per opcode
    localparam int DO_OP_W   = 2;
    localparam int MODE_W    = 4;

    typedef enum logic [5:0] {
        INIT, SYNC, IMM0, DATA, ABS0, ABS1, ZERO, PULL, RDWR,
        RTS0, RTS1, RTS2, PUSH, JSR0, JSR1, JSR2,
        BRK0, BRK1, BRK2, BRK3, COND
    } state_t;

    typedef enum logic [DB_W-1:0] {
        OP_BRK      = 8'h00,
        OP_ASL_ZP   = 8'h06,
        OP_ORA_IMM  = 8'h09,
        OP_JSR      = 8'h20,
        OP_AND_IMM  = 8'h29,
        OP_PHA      = 8'h48,
        OP_EOR_IMM  = 8'h49,
        OP_JMP_ABS  = 8'h4C,
        OP_RTS      = 8'h60,
        OP_PLA      = 8'h68,
        OP_ADC_IMM  = 8'h69,
        OP_BRA      = 8'h80,
        OP_LDY_IMM  = 8'hA0,
        OP_LDX_IMM  = 8'hA2,
        OP_LDA_ZP   = 8'hA5,
        OP_LDA_IMM  = 8'hA9,
        OP_LDA_ABS  = 8'hAD,
        OP_LDA_ZPX  = 8'hB5,
        OP_LDX_ZPY  = 8'hB6,
        OP_LDA_ABSY = 8'hB9,
        OP_LDA_ABSX = 8'hBD,
        OP_CMP_IMM  = 8'hC9,
        OP_DEX      = 8'hCA,
        OP_INC_ZP   = 8'hE6,
        OP_INX      = 8'hE8,
        OP_SBC_IMM  = 8'hE9,
        OP_INC_ABS  = 8'hEE
    } opcode_t;

    typedef enum logic [MODE_W-1:0] {
        AB_KEEP     = 4'd0,              // AB held, AHL <= DB
        AB_PC       = 4'd1,              // Back to PC
        AB_ABS_IDX  = 4'd2,              // {DB, AHL+reg}, PC <= AB+1
        AB_ZP_IDX   = 4'd3,              // {00, DB+reg}
        AB_INC      = 4'd4,              // AB + 1
        AB_POP      = 4'd5,              // {01, SP+1}
        AB_BRANCH   = 4'd7,              // AB + offset + 1
        AB_SP       = 4'd8,              // {01, SP}, keep PC
        AB_SP_STORE = 4'd9,              // {01, SP}, PC <= AB+1
        AB_SP_LOAD  = 4'd11,
        AB_ABS_INC  = 4'd14,             // {DB, AHL+reg} + 1
        AB_VECTOR   = 4'd15              // {FF, vector} + 1
    } ab_mode_t;

    typedef enum logic [2:0] {
        ALU_OR, ALU_AND, ALU_XOR, ALU_ADD, ALU_INC, ALU_DEC, ALU_SUB, ALU_TRB
    } alu_add_t;

    localparam logic [3:0] REG_X   = 4'd0;
    localparam logic [3:0] REG_Y   = 4'd1;
    localparam logic [3:0] REG_A   = 4'd2;
    localparam logic [3:0] REG_S   = 4'd3;
    localparam logic [3:0] REG_M   = 4'd5;    // Memory operand
    localparam logic [3:0] REG_Z   = 4'd7;    // Zero
    localparam logic [3:0] REG_VEC = 4'd10;   // BRK vector
    localparam logic [1:0] DST_X   = 2'd0;
    localparam logic [1:0] DST_Y   = 2'd1;
    localparam logic [1:0] DST_A   = 2'd2;
    localparam logic [1:0] DST_S   = 2'd3;

    localparam logic [DO_OP_W-1:0] DO_ALU = 2'd0;
    localparam logic [DO_OP_W-1:0] DO_P   = 2'd1;
    localparam logic [DO_OP_W-1:0] DO_PCL = 2'd2;
    localparam logic [DO_OP_W-1:0] DO_PCH = 2'd3;

endpackage
`default_nettype wire

// File: hw/ctl_fsm.sv
`default_nettype none
// ##############################
// Instruction cycle sequencer
// Steps the per-opcode state chain
// and registers the write enable
// ##############################
module ctl_fsm import ctl_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst_n,
    input  wire state_t entry_state,    // From opcode lookup
    input  wire logic   rmw,            // Read-modify-write instruction
    input  wire logic   jmp,            // Absolute address goes to PC
    output state_t      state,
    output logic        sync,
    output logic        we
);

    state_t state_nxt;

    assign sync = (state == SYNC);      // Opcode fetch cycle

    always_comb begin
        state_nxt = SYNC;
        case (state)
            INIT: state_nxt = SYNC;
            SYNC: state_nxt = entry_state;
            IMM0: state_nxt = SYNC;
            ABS0: state_nxt = ABS1;     // Low address byte fetched
            ABS1: begin
                if (jmp) begin
                    state_nxt = SYNC;   // JMP, JSR, BRK land here
                end else if (rmw) begin
                    state_nxt = RDWR;
                end else begin
                    state_nxt = DATA;
                end
            end
            ZERO: state_nxt = rmw ? RDWR : DATA;
            RDWR: state_nxt = DATA;     // Modify, write back next
            DATA: state_nxt = SYNC;
            PULL: state_nxt = DATA;
            PUSH: state_nxt = DATA;
            RTS0: state_nxt = RTS1;
            RTS1: state_nxt = RTS2;
            RTS2: state_nxt = SYNC;
            JSR0: state_nxt = JSR1;
            JSR1: state_nxt = JSR2;
            JSR2: state_nxt = ABS1;     // Target high byte
            BRK0: state_nxt = BRK1;
            BRK1: state_nxt = BRK2;
            BRK2: state_nxt = BRK3;
            BRK3: state_nxt = ABS0;     // Fetch through vector
            COND: state_nxt = SYNC;
            default: state_nxt = SYNC;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= INIT;
        end else begin
            state <= state_nxt;
        end
    end

    // Memory write happens in the cycle after each store state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            we <= 1'b0;
        end else begin
            case (state)
                BRK0, BRK1, BRK2: we <= 1'b1;   // PCH, PCL, P to stack
                JSR0, JSR1:       we <= 1'b1;   // Return address
                PUSH:             we <= 1'b1;
                RDWR:             we <= 1'b1;   // Write back modified value
                default:          we <= 1'b0;
            endcase
        end
    end

endmodule
`default_nettype wire

// File: hw/opcode_decode.sv
`default_nettype none
// ##############################
// Opcode decoder
// Entry state lookup and flags
// latched at the end of sync
// ##############################
module opcode_decode import ctl_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic [DB_W-1:0]        db,
    input  wire logic                   sync,
    output state_t                      entry_state,
    output logic                        rmw,
    output logic                        jmp,
    output logic                        add_x,
    output logic                        add_y,
    output logic                        ld,
    output logic                        st,
    output logic [3:0]                  src,
    output logic [1:0]                  dst,
    output logic [ALU_SEL_W-1:0]        alu_sel
);

    logic                   rmw_d, jmp_d, add_x_d, add_y_d, ld_d, st_d;
    logic [3:0]             src_d;
    logic [1:0]             dst_d;
    logic [ALU_SEL_W-1:0]   alu_sel_d;

    assign rmw_d   = db inside {OP_ASL_ZP, OP_INC_ZP, OP_INC_ABS};
    assign jmp_d   = db inside {OP_BRK, OP_JSR, OP_JMP_ABS, OP_RTS};
    assign add_x_d = db inside {OP_LDA_ZPX, OP_LDA_ABSX};
    assign add_y_d = db inside {OP_LDX_ZPY, OP_LDA_ABSY};
    assign st_d    = (db == OP_PHA);
    assign ld_d    = db inside {OP_LDA_IMM, OP_LDY_IMM, OP_LDX_IMM, OP_LDA_ZP, OP_LDA_ZPX,
                                OP_LDX_ZPY, OP_LDA_ABS, OP_LDA_ABSX, OP_LDA_ABSY, OP_PLA,
                                OP_ORA_IMM, OP_AND_IMM, OP_EOR_IMM, OP_ADC_IMM, OP_SBC_IMM,
                                OP_DEX, OP_INX};

    always_comb begin
        entry_state = SYNC;     // Unknown opcodes, DEX and INX stay here
        src_d       = REG_X;
        dst_d       = DST_X;
        alu_sel_d   = '0;
        case (db)
            OP_LDA_IMM, OP_LDY_IMM, OP_LDX_IMM, OP_ORA_IMM, OP_AND_IMM,
            OP_EOR_IMM, OP_ADC_IMM, OP_CMP_IMM, OP_SBC_IMM: entry_state = IMM0;
            OP_LDA_ZP, OP_LDA_ZPX, OP_LDX_ZPY, OP_ASL_ZP, OP_INC_ZP: entry_state = ZERO;
            OP_LDA_ABS, OP_LDA_ABSX, OP_LDA_ABSY, OP_INC_ABS, OP_JMP_ABS: entry_state = ABS0;
            OP_PHA: entry_state = PUSH;
            OP_PLA: entry_state = PULL;
            OP_JSR: entry_state = JSR0;
            OP_RTS: entry_state = RTS0;
            OP_BRK: entry_state = BRK0;
            OP_BRA: entry_state = COND;
            default: entry_state = SYNC;
        endcase
        case (db)
            OP_LDA_IMM, OP_LDA_ZP, OP_LDA_ZPX, OP_LDA_ABS, OP_LDA_ABSX, OP_LDA_ABSY,
            OP_PLA: begin
                src_d = REG_Z;
                dst_d = DST_A;
            end
            OP_LDX_IMM, OP_LDX_ZPY: src_d = REG_Z;      // dst stays X
            OP_LDY_IMM: begin
                src_d = REG_Z;
                dst_d = DST_Y;
            end
            OP_ORA_IMM, OP_AND_IMM, OP_EOR_IMM, OP_ADC_IMM, OP_CMP_IMM, OP_SBC_IMM: begin
                src_d = REG_A;
                dst_d = DST_A;
            end
            OP_PHA: src_d = REG_A;
            OP_INC_ZP, OP_INC_ABS: src_d = REG_M;
            default: src_d = REG_X;                   // DEX, INX use X both ways
        endcase
        case (db)
            OP_ORA_IMM: alu_sel_d = {2'b00, ALU_OR, 2'b00};
            OP_AND_IMM: alu_sel_d = {2'b00, ALU_AND, 2'b00};
            OP_EOR_IMM: alu_sel_d = {2'b00, ALU_XOR, 2'b00};
            OP_ADC_IMM: alu_sel_d = {2'b00, ALU_ADD, 2'b11};    // Carry in from C
            OP_SBC_IMM: alu_sel_d = {2'b00, ALU_SUB, 2'b11};
            OP_DEX:     alu_sel_d = {2'b00, ALU_DEC, 2'b00};
            OP_INX:     alu_sel_d = {2'b00, ALU_INC, 2'b01};
            OP_LDA_IMM, OP_LDY_IMM, OP_LDX_IMM, OP_LDA_ZP, OP_LDA_ZPX, OP_LDX_ZPY,
            OP_LDA_ABS, OP_LDA_ABSX, OP_LDA_ABSY, OP_INC_ZP, OP_INC_ABS, OP_PHA,
            OP_PLA:     alu_sel_d = {2'b00, ALU_ADD, 2'b00};    // Pass through
            default:    alu_sel_d = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            {rmw, jmp, add_x, add_y, ld, st} <= '0;
            src     <= '0;
            dst     <= '0;
            alu_sel <= '0;
        end else if (sync) begin
            {rmw, jmp, add_x, add_y, ld, st} <= {rmw_d, jmp_d, add_x_d, add_y_d, ld_d, st_d};
            src     <= src_d;
            dst     <= dst_d;
            alu_sel <= alu_sel_d;
        end
    end

endmodule
`default_nettype wire

// File: hw/addr_mode_enc.sv
`default_nettype none
// ##############################
// Address bus control encoder
// State to mode, mode to ab_op
// ##############################
module addr_mode_enc import ctl_pkg::*; (
    input  wire state_t             state,
    input  wire logic               db7,       // Offset sign
    input  wire logic               cond,      // Branch taken
    output logic [AB_OP_W-1:0]      ab_op
);

    ab_mode_t   mode;
    logic [1:0] abl_sel;
    logic       abl_ci;
    logic       back;

    assign abl_sel = mode[1:0];     // Straight to ABL mux
    assign abl_ci  = mode[2];       // ABL carry in
    assign back    = cond & db7;    // Taken backward branch

    always_comb begin
        case (state)
            SYNC, IMM0, ABS0:   mode = AB_INC;
            ABS1:               mode = AB_ABS_IDX;
            ZERO:               mode = AB_ZP_IDX;
            DATA, JSR2:         mode = AB_PC;
            PULL, RTS0, RTS1:   mode = AB_POP;
            PUSH:               mode = AB_SP_LOAD;
            RTS2:               mode = AB_ABS_INC;
            JSR0, BRK0:         mode = AB_SP_STORE;
            JSR1, BRK1, BRK2:   mode = AB_SP;
            BRK3:               mode = AB_VECTOR;
            COND:               mode = AB_BRANCH;
            default:            mode = AB_KEEP;    // INIT, RDWR
        endcase
    end

    always_comb begin
        case (mode)
            AB_KEEP:     ab_op = {7'b001_0110, abl_sel, 2'b11, abl_ci};
            AB_PC:       ab_op = {7'b000_1010, abl_sel, 2'b10, abl_ci};
            AB_ABS_IDX:  ab_op = {7'b111_1110, abl_sel, 2'b01, abl_ci};
            AB_ZP_IDX:   ab_op = {7'b111_0000, abl_sel, 2'b01, abl_ci};
            AB_INC:      ab_op = {7'b011_0110, abl_sel, 2'b11, abl_ci};
            AB_POP:      ab_op = {7'b011_0001, abl_sel, 2'b00, abl_ci};
            AB_BRANCH:   ab_op = back ? {7'b011_0111, abl_sel, 2'b11, abl_ci}  // ABH - 1
                                      : {7'b011_0110, abl_sel, 2'b11, abl_ci};
            AB_SP:       ab_op = {7'b000_0001, abl_sel, 2'b00, abl_ci};
            AB_SP_STORE: ab_op = {7'b111_0001, abl_sel, 2'b00, abl_ci};
            AB_SP_LOAD:  ab_op = {7'b010_0001, abl_sel, 2'b00, abl_ci};
            AB_ABS_INC:  ab_op = {7'b001_1110, abl_sel, 2'b01, abl_ci};
            AB_VECTOR:   ab_op = {7'b000_0011, abl_sel, 2'b00, abl_ci};
            default:     ab_op = '0;
        endcase
    end

endmodule
`default_nettype wire

// File: hw/op_word_enc.sv
`default_nettype none
// ##############################
// Register, ALU and data-out
// control word encoder
// ##############################
module op_word_enc import ctl_pkg::*; (
    input  wire state_t                 state,
    input  wire logic                   add_x,
    input  wire logic                   add_y,
    input  wire logic                   ld,
    input  wire logic                   st,
    input  wire logic [3:0]             src,
    input  wire logic [1:0]             dst,
    input  wire logic [ALU_SEL_W-1:0]   alu_sel,
    output logic [REG_OP_W-1:0]         reg_op,
    output logic [ALU_OP_W-1:0]         alu_op,
    output logic [DO_OP_W-1:0]          do_op
);

    logic [3:0] idx_src;

    // Index register added to the address
    assign idx_src = add_x ? REG_X : (add_y ? REG_Y : REG_Z);

    always_comb begin
        case (state)
            BRK0, BRK1, BRK2, JSR0, JSR1,
            RTS0, RTS1, PUSH, PULL: reg_op = {1'b1, DST_S, REG_S};  // Update SP
            BRK3:                   reg_op = {1'b0, 2'b00, REG_VEC};
            ZERO, ABS1:             reg_op = {1'b0, 2'b00, idx_src};
            SYNC:                   reg_op = {ld, dst, src};          // Finish previous op
            DATA:                   reg_op = {1'b0, dst, src};        // Store source
            default:                reg_op = {1'b0, 2'b00, REG_Z};
        endcase
    end

    always_comb begin
        case (state)
            BRK0, BRK1, BRK2,
            JSR0, JSR1, PUSH:   alu_op = {4'b0000, ALU_DEC, 2'b00};     // SP - 1
            RTS0, RTS1, PULL:   alu_op = {4'b0000, ALU_INC, 2'b01};     // SP + 1
            IMM0, RDWR:         alu_op = {4'b1000, ALU_OR, 2'b00};      // Load M
            SYNC:               alu_op = {2'b00, alu_sel};
            DATA: begin
                if (st) begin
                    alu_op = {4'b0000, ALU_INC, 2'b00};  // Pass to M
                end else begin
                    alu_op = {2'b10, alu_sel};           // Load or RMW result
                end
            end
            default:            alu_op = '0;
        endcase
    end

    always_comb begin
        case (state)
            BRK1, JSR1: do_op = DO_PCH;
            BRK2, JSR2: do_op = DO_PCL;
            BRK3:       do_op = DO_P;       // Status last
            default:    do_op = DO_ALU;     // DATA and idle
        endcase
    end

endmodule
`default_nettype wire

// File: hw/ctl_top.sv
`default_nettype none
// ##############################
// 6502 control unit top
// Sequencer, decoder and encoders
// ##############################
module ctl_top import ctl_pkg::*; (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic [DB_W-1:0]     db,        // Opcode / operand bus
    input  wire logic                cond,      // Branch condition
    output logic                     sync,
    output logic                     we,
    output logic [AB_OP_W-1:0]       ab_op,
    output logic [REG_OP_W-1:0]      reg_op,
    output logic [ALU_OP_W-1:0]      alu_op,
    output logic [DO_OP_W-1:0]       do_op
);

    state_t                 state;
    state_t                 entry_state;            // State after SYNC
    logic                   rmw, jmp;
    logic                   add_x, add_y, ld, st;
    logic [3:0]             src;
    logic [1:0]             dst;
    logic [ALU_SEL_W-1:0]   alu_sel;

    ctl_fsm i_ctl_fsm (
        .clk(clk), .rst_n(rst_n), .entry_state(entry_state), .rmw(rmw), .jmp(jmp),
        .state(state), .sync(sync), .we(we)
    );

    opcode_decode i_opcode_decode (
        .clk(clk), .rst_n(rst_n), .db(db), .sync(sync), .entry_state(entry_state),
        .rmw(rmw), .jmp(jmp), .add_x(add_x), .add_y(add_y), .ld(ld), .st(st),
        .src(src), .dst(dst), .alu_sel(alu_sel)
    );

    addr_mode_enc i_addr_mode_enc (
        .state(state), .db7(db[7]), .cond(cond), .ab_op(ab_op)
    );

    op_word_enc i_op_word_enc (
        .state(state), .add_x(add_x), .add_y(add_y), .ld(ld), .st(st), .src(src),
        .dst(dst), .alu_sel(alu_sel), .reg_op(reg_op), .alu_op(alu_op), .do_op(do_op)
    );

endmodule
`default_nettype wire

// File: test/ctl_checker.sv
`default_nettype none
// ##############################
// Sequencer protocol assertions
// Sync pulse, write enable, reset
// ##############################
module ctl_checker import ctl_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst_n,
    input  wire logic   sync,
    input  wire logic   we,
    input  wire state_t entry_state     // Decoder lookup of the opcode on db
);

    int fail_cnt;                       // Assertion failures so far

    // No memory write while an opcode is fetched
    sync_we_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(sync && we))
        else begin
            $error("sync and we are high in the same cycle");
            fail_cnt++;
        end

    // Multi-cycle opcodes leave SYNC after one cycle
    sync_single: assert property (@(posedge clk) disable iff (!rst_n)
        (sync && (entry_state != SYNC)) |=> !sync)
        else begin
            $error("sync stays high after a multi-cycle opcode");
            fail_cnt++;
        end

    we_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |=> !we)               // First cycle out of reset
        else begin
            $error("we is high in the cycle after reset release");
            fail_cnt++;
        end

endmodule
`default_nettype wire

// File: test/ctl_tb.sv
`default_nettype none
// ##############################
// 6502 sequencer testbench
// Opcode stream, reference model
// and per-instruction checks
// ##############################
module ctl_tb import ctl_pkg::*; ();

    localparam int SEED     = 79160;
    localparam int N_DIR    = 29;
    localparam int N_INSTR  = 69;                       // Directed plus random run
    localparam int WATCHDOG = (N_INSTR * 7 + 50) * 10;  // Worst case 7 cycles each
    localparam logic [3:0] M_BR  = AB_BRANCH;
    localparam logic [3:0] M_VEC = AB_VECTOR;
    localparam logic [AB_OP_W-1:0] BR_FWD  = {7'b011_0110, M_BR[1:0], 2'b11, M_BR[2]};
    localparam logic [AB_OP_W-1:0] BR_BACK = {7'b011_0111, M_BR[1:0], 2'b11, M_BR[2]};
    localparam logic [AB_OP_W-1:0] VEC_AB  = {7'b000_0011, M_VEC[1:0], 2'b00, M_VEC[2]};
    localparam logic [DB_W-1:0] DIRECTED [N_DIR] = '{
        OP_LDA_IMM, OP_LDY_IMM, OP_LDX_IMM, OP_ORA_IMM, OP_AND_IMM, OP_EOR_IMM,
        OP_ADC_IMM, OP_CMP_IMM, OP_SBC_IMM, OP_LDA_ZP, OP_LDA_ZPX, OP_LDX_ZPY,
        OP_ASL_ZP, OP_INC_ZP, OP_LDA_ABS, OP_LDA_ABSX, OP_LDA_ABSY, OP_INC_ABS,
        OP_JMP_ABS, OP_PHA, OP_PLA, OP_JSR, OP_RTS, OP_BRK, OP_BRA, OP_DEX,
        OP_INX, 8'hEA, 8'hFF                            // Last two unlisted
    };

    logic                   clk = 1'b0;
    logic                   rst_n, cond, sync, we;
    logic [DB_W-1:0]        db;
    logic [AB_OP_W-1:0]     ab_op;
    logic [REG_OP_W-1:0]    reg_op, exp_reg;
    logic [ALU_OP_W-1:0]    alu_op, exp_alu;
    logic [DO_OP_W-1:0]     do_op;
    logic [DB_W-1:0]        op_list [N_INSTR];
    logic [DB_W-1:0]        cur_op;
    logic                   cur_valid, exp_words;
    int                     issue_idx, cyc, wcnt, exp_cyc, exp_wr;
    int                     errors, err_start, tests_done, tests_failed;

    ctl_top i_ctl_top (
        .clk(clk), .rst_n(rst_n), .db(db), .cond(cond), .sync(sync), .we(we),
        .ab_op(ab_op), .reg_op(reg_op), .alu_op(alu_op), .do_op(do_op)
    );

    bind ctl_top ctl_checker i_ctl_checker (
        .clk(clk), .rst_n(rst_n), .sync(sync), .we(we), .entry_state(entry_state)
    );

    // Cycles, writes and the SYNC-cycle words left behind by one opcode
    function automatic void ref_instr(input logic [DB_W-1:0] op, output int cycles,
                                      output int writes, output logic words,
                                      output logic [REG_OP_W-1:0] r_op,
                                      output logic [ALU_OP_W-1:0] a_op);
        logic [3:0] src;
        logic [1:0] dst;
        logic [2:0] add;
        logic [1:0] carry;
        cycles = 1;
        writes = 0;
        words  = 1'b1;
        src    = REG_Z;                                 // Loads pass memory through
        dst    = DST_A;
        add    = ALU_ADD;
        carry  = 2'b00;
        case (op)
            OP_LDA_IMM, OP_LDY_IMM, OP_LDX_IMM, OP_ORA_IMM, OP_AND_IMM, OP_EOR_IMM,
            OP_ADC_IMM, OP_CMP_IMM, OP_SBC_IMM, OP_BRA: cycles = 2;
            OP_LDA_ZP, OP_LDA_ZPX, OP_LDX_ZPY, OP_JMP_ABS, OP_PLA: cycles = 3;
            OP_PHA: {cycles, writes} = {32'd3, 32'd1};
            OP_ASL_ZP, OP_INC_ZP: {cycles, writes} = {32'd4, 32'd1};
            OP_LDA_ABS, OP_LDA_ABSX, OP_LDA_ABSY, OP_RTS: cycles = 4;
            OP_INC_ABS: {cycles, writes} = {32'd5, 32'd1};
            OP_JSR: {cycles, writes} = {32'd5, 32'd2};  // PCH, PCL
            OP_BRK: {cycles, writes} = {32'd7, 32'd3};  // PCH, PCL, P
            default: cycles = 1;
        endcase
        case (op)
            OP_LDA_IMM, OP_LDA_ZP, OP_LDA_ZPX, OP_LDA_ABS, OP_LDA_ABSX, OP_LDA_ABSY: ;
            OP_LDX_IMM, OP_LDX_ZPY: dst = DST_X;
            OP_LDY_IMM: dst = DST_Y;
            OP_ORA_IMM: {src, add} = {REG_A, ALU_OR};
            OP_AND_IMM: {src, add} = {REG_A, ALU_AND};
            OP_EOR_IMM: {src, add} = {REG_A, ALU_XOR};
            OP_ADC_IMM: {src, add, carry} = {REG_A, ALU_ADD, 2'b11};    // Carry from C
            OP_SBC_IMM: {src, add, carry} = {REG_A, ALU_SUB, 2'b11};
            default: words = 1'b0;                      // No register result to check
        endcase
        r_op = {1'b1, dst, src};
        a_op = {2'b00, 2'b00, add, carry};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expv);
        assert (got === expv) else begin
            $display("ERROR t=%0t %s got %0h expected %0h", $time, name, got, expv);
            errors++;
        end
    endtask

    initial begin
        forever #5 clk = ~clk;
    end

    // Opcode on each sync, random operands and condition otherwise
    initial begin
        issue_idx = 0;
        forever begin
            @(posedge clk);
            #1;
            if (rst_n && sync) begin
                db = (issue_idx < N_INSTR) ? op_list[issue_idx] : 8'hFF;
                issue_idx++;
            end else begin
                db = $urandom % 256;
            end
            cond = $urandom % 2;
        end
    end

    always @(negedge clk) begin
        if (!rst_n) begin
            check_value("sync", sync, 1'b0);
            check_value("we", we, 1'b0);
        end else if (sync) begin
            if (cur_valid) begin
                wcnt = wcnt + we;                       // Write in the next sync counts
                ref_instr(cur_op, exp_cyc, exp_wr, exp_words, exp_reg, exp_alu);
                check_value("cycles", cyc, exp_cyc);
                check_value("we count", wcnt, exp_wr);
                if (exp_words) begin
                    check_value("reg_op", reg_op, exp_reg);
                    check_value("alu_op", alu_op, exp_alu);
                end
                if (errors != err_start) tests_failed++;
                $display("op %02h: %0d cycles, %0d writes, %s", cur_op, cyc, wcnt,
                         (errors == err_start) ? "ok" : "bad");
                tests_done++;
            end
            cur_op    = db;                             // New opcode fetched
            cur_valid = 1'b1;
            cyc       = 1;
            wcnt      = 0;
            err_start = errors;
        end else if (cur_valid) begin
            cyc++;
            wcnt = wcnt + we;
            if (cur_op == OP_BRA && cyc == 2) begin     // COND cycle
                check_value("ab_op", ab_op, (cond && db[7]) ? BR_BACK : BR_FWD);
            end
            if (cur_op == OP_BRK) begin
                case (cyc)
                    3: check_value("do_op", do_op, DO_PCH);
                    4: check_value("do_op", do_op, DO_PCL);
                    5: begin                            // BRK3
                        check_value("do_op", do_op, DO_P);
                        check_value("ab_op", ab_op, VEC_AB);
                    end
                    default: ;
                endcase
            end
        end
    end

    initial begin
        #(WATCHDOG);
        $display("Timeout: the instruction stream did not finish in time");
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        rst_n        = 1'b0;
        db           = '0;
        cond         = 1'b0;
        cur_op       = '0;
        cur_valid    = 1'b0;
        {cyc, wcnt, errors, err_start, tests_done, tests_failed} = '0;
        for (int i = 0; i < N_INSTR; i++) begin
            if (i < N_DIR) begin
                op_list[i] = DIRECTED[i];
            end else if ($urandom % 4 == 0) begin
                op_list[i] = $urandom % 256;            // Any byte, often unlisted
            end else begin
                op_list[i] = DIRECTED[$urandom % N_DIR];
            end
        end
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
        @(posedge clk);
        @(negedge clk);
        #1;
        check_value("sync", sync, 1'b1);                // First cycle after release
        if (errors != 0) tests_failed++;
        $display("reset: %s", (errors == 0) ? "ok" : "bad");
        wait (tests_done == N_INSTR);
        errors = errors + i_ctl_top.i_ctl_checker.fail_cnt;     // Protocol assertions
        $display("tests %0d, failed %0d, errors %0d", N_INSTR + 1, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
`default_nettype wire

// File: build.f
hw/ctl_pkg.sv
hw/ctl_fsm.sv
hw/opcode_decode.sv
hw/addr_mode_enc.sv
hw/op_word_enc.sv
hw/ctl_top.sv
test/ctl_checker.sv
test/ctl_tb.sv
